// File: include/ntm_params.svh
/* NTM addressing build-time sizes
   Vector length, index and word widths, fixed-point scale */
`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

// Memory rows in one weighting
`define NTM_SIZE_N 8
// Row index, wide enough for N rows
`define NTM_INDEX_WIDTH 3

// Weighting word
`define NTM_WORD_WIDTH 16
// Unsigned fixed point, 8 fraction bits
`define NTM_FRAC_BITS 8
// Fixed-point 1.0
`define NTM_ONE 256

`endif

// File: source/ntm_pkg.sv
/* NTM addressing shared types
   Words, gates, indices, element pairs, kernel and FSM states */
`include "ntm_params.svh"

package ntm_pkg;

  // One weighting element
  typedef logic [`NTM_WORD_WIDTH-1:0] word_t;
  // Gate or kernel tap, 0 to 1.0 inclusive
  typedef logic [`NTM_FRAC_BITS:0] gate_t;
  // Row index
  typedef logic [`NTM_INDEX_WIDTH-1:0] index_t;
  // Three products of word by tap, summed
  typedef logic [`NTM_WORD_WIDTH+`NTM_FRAC_BITS+2:0] acc_t;

  // Content and previous weighting for one row
  typedef struct packed {
    word_t content;
    word_t previous;
  } addr_elem_t;

  // Three-tap shift kernel
  typedef struct packed {
    gate_t s_prev;
    gate_t s_zero;
    gate_t s_next;
  } shift_kernel_t;

  typedef enum logic [1:0] {idle, load, convolve, finish} ctrl_state_t;

endpackage

// File: source/ntm_addressing_ctrl.sv
/* NTM addressing step controller
   Latches g and s, waits for the load, runs convolution, pulses READY */
`timescale 1ns/1ns

module ntm_addressing_ctrl (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  ntm_pkg::gate_t         G_IN,
  input  ntm_pkg::shift_kernel_t S_IN,
  input  logic                   loaded,
  input  logic                   conv_done,
  output logic                   load_phase,
  output ntm_pkg::gate_t         gate,
  output ntm_pkg::shift_kernel_t kernel,
  output logic                   conv_start,
  output logic                   READY
);

  ntm_pkg::ctrl_state_t state;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_pkg::idle;
      conv_start <= 1'b0;
    end else begin
      // Single-cycle pulse by default
      conv_start <= 1'b0;

      case (state)
        ntm_pkg::idle: begin
          // Only an idle controller takes START
          if (START) begin
            state <= ntm_pkg::load;
          end
        end

        ntm_pkg::load: begin
          // All N interpolated words are in the buffer
          if (loaded) begin
            conv_start <= 1'b1;
            state      <= ntm_pkg::convolve;
          end
        end

        ntm_pkg::convolve: begin
          // Last output is on W_OUT this cycle
          if (conv_done) begin
            state <= ntm_pkg::finish;
          end
        end

        ntm_pkg::finish: begin
          state <= ntm_pkg::idle;
        end

        default: begin
          state <= ntm_pkg::idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////

  // Gate and kernel held for the whole run
  always_ff @(posedge CLK) begin
    if (state == ntm_pkg::idle && START) begin
      gate   <= G_IN;
      kernel <= S_IN;
    end
  end

  // Strobes are accepted only while loading
  assign load_phase = (state == ntm_pkg::load);

  // Finish lasts one cycle, right after the last output
  assign READY = (state == ntm_pkg::finish);

endmodule

// File: source/ntm_interpolation.sv
/* Gated interpolation of content and previous weightings
   One registered blended word per accepted element strobe */
`timescale 1ns/1ns
`include "ntm_params.svh"

module ntm_interpolation (
  input  logic                CLK,
  input  logic                RST,
  input  logic                load_phase,
  input  ntm_pkg::gate_t      gate,
  input  ntm_pkg::addr_elem_t ELEM_IN,
  input  logic                ELEM_IN_ENABLE,
  output logic                wr_en,
  output ntm_pkg::index_t     wr_index,
  output ntm_pkg::word_t      wr_data,
  output logic                loaded
);

  logic            accept;
  logic            full;
  ntm_pkg::index_t count;
  ntm_pkg::gate_t  gate_inv;
  ntm_pkg::acc_t   blend;

  // Drop strobes outside the load and past the Nth element
  assign accept = ELEM_IN_ENABLE && load_phase && !full;

  // 1 - g, then two products and one sum
  assign gate_inv = ntm_pkg::gate_t'(`NTM_ONE) - gate;
  assign blend = ntm_pkg::acc_t'(gate) * ntm_pkg::acc_t'(ELEM_IN.content)
               + ntm_pkg::acc_t'(gate_inv) * ntm_pkg::acc_t'(ELEM_IN.previous);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_en  <= 1'b0;
      loaded <= 1'b0;
      count  <= '0;
      full   <= 1'b0;
    end else begin
      wr_en  <= accept;
      // Cycle after the write of row N-1
      loaded <= wr_en && (wr_index == ntm_pkg::index_t'(`NTM_SIZE_N - 1));
      if (!load_phase) begin
        // Ready for the next run
        count <= '0;
        full  <= 1'b0;
      end else if (accept) begin
        count <= count + 1'b1;
        if (count == ntm_pkg::index_t'(`NTM_SIZE_N - 1)) begin
          full <= 1'b1;
        end
      end
    end
  end

  // Result and its row, written to the buffer next cycle
  always_ff @(posedge CLK) begin
    if (accept) begin
      wr_index <= count;
      wr_data  <= ntm_pkg::word_t'(blend >> `NTM_FRAC_BITS);
    end
  end

endmodule

// File: source/ntm_weight_buffer.sv
/* Interpolated weighting store
   N words, one write port, one registered read port */
`timescale 1ns/1ns
`include "ntm_params.svh"

module ntm_weight_buffer (
  input  logic            CLK,
  input  logic            wr_en,
  input  ntm_pkg::index_t wr_index,
  input  ntm_pkg::word_t  wr_data,
  input  ntm_pkg::index_t rd_index,
  output ntm_pkg::word_t  rd_data
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // One word per memory row
  ntm_pkg::word_t mem [`NTM_SIZE_N];

  // Write side, fed by the interpolation unit
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // Read side, data one clock after the index
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_index];
  end

endmodule

// File: source/ntm_shift_convolution.sv
/* Three-tap circular shift convolution
   Reads wg from the buffer and emits one saturated output every 4 cycles */
`timescale 1ns/1ns
`include "ntm_params.svh"

module ntm_shift_convolution (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   conv_start,
  input  ntm_pkg::shift_kernel_t kernel,
  output ntm_pkg::index_t        rd_index,
  input  ntm_pkg::word_t         rd_data,
  output ntm_pkg::word_t         W_OUT,
  output logic                   W_OUT_ENABLE,
  output logic                   conv_done
);

  logic            busy;
  logic [1:0]      tap;
  ntm_pkg::index_t j;
  ntm_pkg::gate_t  coef;
  ntm_pkg::acc_t   acc;
  ntm_pkg::acc_t   product;
  ntm_pkg::acc_t   total;
  ntm_pkg::acc_t   scaled;
  ntm_pkg::word_t  sat_word;
  logic            last_tap;
  logic            last_elem;

  ////////////////////////////////////////////////////////////
  // Tap sequencing
  ////////////////////////////////////////////////////////////

  // Reads j+1, j and j-1 with the 3-bit index wrapping mod N
  always_comb begin
    case (tap)
      2'd0:    rd_index = ntm_pkg::index_t'(j + 1'b1);
      2'd1:    rd_index = j;
      2'd2:    rd_index = ntm_pkg::index_t'(j - 1'b1);
      default: rd_index = j;
    endcase
  end

  // Data lags the read by one cycle, so the taps do too
  always_comb begin
    case (tap)
      2'd1:    coef = kernel.s_prev;
      2'd2:    coef = kernel.s_zero;
      2'd3:    coef = kernel.s_next;
      default: coef = '0;
    endcase
  end

  assign product = ntm_pkg::acc_t'(coef) * ntm_pkg::acc_t'(rd_data);
  // First tap restarts the sum
  assign total   = (tap == 2'd1) ? product : acc + product;
  assign scaled  = total >> `NTM_FRAC_BITS;

  // Clamp anything above FFFF
  assign sat_word = (|scaled[$bits(ntm_pkg::acc_t)-1:`NTM_WORD_WIDTH]) ?
                    '1 : scaled[`NTM_WORD_WIDTH-1:0];

  assign last_tap  = busy && (tap == 2'd3);
  assign last_elem = (j == ntm_pkg::index_t'(`NTM_SIZE_N - 1));

  ////////////////////////////////////////////////////////////
  // Control and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy         <= 1'b0;
      tap          <= '0;
      j            <= '0;
      W_OUT        <= '0;
      W_OUT_ENABLE <= 1'b0;
      conv_done    <= 1'b0;
    end else begin
      W_OUT_ENABLE <= last_tap;
      conv_done    <= last_tap && last_elem;
      if (conv_start) begin
        busy <= 1'b1;
        tap  <= '0;
        j    <= '0;
      end else if (busy) begin
        tap <= tap + 1'b1;
        if (tap == 2'd3) begin
          // End of row moves to the next row or stops
          if (last_elem) begin
            busy <= 1'b0;
          end else begin
            j <= j + 1'b1;
          end
        end
      end
      if (last_tap) begin
        W_OUT <= sat_word;
      end
    end
  end

  // Partial sum across the three taps
  always_ff @(posedge CLK) begin
    if (busy && tap != 2'd0) begin
      acc <= total;
    end
  end

endmodule

// File: source/ntm_addressing.sv
/* NTM head location addressing
   Gated interpolation followed by circular shift convolution */
`timescale 1ns/1ns

module ntm_addressing (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  ntm_pkg::gate_t         G_IN,
  input  ntm_pkg::shift_kernel_t S_IN,
  input  ntm_pkg::addr_elem_t    ELEM_IN,
  input  logic                   ELEM_IN_ENABLE,
  output ntm_pkg::word_t         W_OUT,
  output logic                   W_OUT_ENABLE,
  output logic                   READY
);

  ////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////

  // Controller to datapath
  logic                   load_phase;
  ntm_pkg::gate_t         gate;
  ntm_pkg::shift_kernel_t kernel;
  logic                   conv_start;

  // Datapath back to controller
  logic                   loaded;
  logic                   conv_done;

  // Interpolated weighting buffer ports
  logic                   wr_en;
  ntm_pkg::index_t        wr_index;
  ntm_pkg::word_t         wr_data;
  ntm_pkg::index_t        rd_index;
  ntm_pkg::word_t         rd_data;

  ////////////////////////////////////////////////////////////
  // Step controller
  ////////////////////////////////////////////////////////////

  ntm_addressing_ctrl i_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .G_IN       (G_IN),
    .S_IN       (S_IN),
    .loaded     (loaded),
    .conv_done  (conv_done),
    .load_phase (load_phase),
    .gate       (gate),
    .kernel     (kernel),
    .conv_start (conv_start),
    .READY      (READY)
  );

  ////////////////////////////////////////////////////////////
  // Datapath steps
  ////////////////////////////////////////////////////////////

  // wg = g*wc + (1-g)*w_prev, one element per strobe
  ntm_interpolation i_interp (
    .CLK            (CLK),
    .RST            (RST),
    .load_phase     (load_phase),
    .gate           (gate),
    .ELEM_IN        (ELEM_IN),
    .ELEM_IN_ENABLE (ELEM_IN_ENABLE),
    .wr_en          (wr_en),
    .wr_index       (wr_index),
    .wr_data        (wr_data),
    .loaded         (loaded)
  );

  // Holds wg until the convolution walks it
  ntm_weight_buffer i_buffer (
    .CLK      (CLK),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  // w = wg circularly convolved with s
  ntm_shift_convolution i_conv (
    .CLK          (CLK),
    .RST          (RST),
    .conv_start   (conv_start),
    .kernel       (kernel),
    .rd_index     (rd_index),
    .rd_data      (rd_data),
    .W_OUT        (W_OUT),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .conv_done    (conv_done)
  );

endmodule

// File: sim/ntm_addressing_tb.sv
/* NTM addressing testbench
   Five addressing passes with W_OUT checked against an expected vector */
`timescale 1ns/1ns
`include "ntm_params.svh"

module ntm_addressing_tb;

  localparam int N = `NTM_SIZE_N;
  // Per test the gapped load, 4-cycle outputs and a margin
  localparam int CYCLE_LIMIT = 5 * (N * 4 + N * 4 + 20);

  logic                   CLK;
  logic                   RST;
  logic                   START;
  ntm_pkg::gate_t         G_IN;
  ntm_pkg::shift_kernel_t S_IN;
  ntm_pkg::addr_elem_t    ELEM_IN;
  logic                   ELEM_IN_ENABLE;
  ntm_pkg::word_t         W_OUT;
  logic                   W_OUT_ENABLE;
  logic                   READY;

  integer         seed;
  int             cycle;
  int             errors;
  int             start_errors;
  int             tests_passed;
  int             tests_failed;
  int             out_count;
  int             ready_count;
  int             last_out_cycle;
  ntm_pkg::word_t content_v [N];
  ntm_pkg::word_t previous_v [N];
  ntm_pkg::word_t expected [N];

  ntm_addressing i_dut (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .G_IN           (G_IN),
    .S_IN           (S_IN),
    .ELEM_IN        (ELEM_IN),
    .ELEM_IN_ENABLE (ELEM_IN_ENABLE),
    .W_OUT          (W_OUT),
    .W_OUT_ENABLE   (W_OUT_ENABLE),
    .READY          (READY)
  );

  always #4 CLK = ~CLK;

  // Run length guard
  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output collector sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && W_OUT_ENABLE) begin
      assert (out_count < N) else begin
        $display("More than %0d output pulses arrived in one pass", N);
        errors++;
      end
      if (out_count < N) begin
        assert (W_OUT == expected[out_count]) else begin
          $display("[FAIL] W_OUT[%0d] expected %h got %h", out_count, expected[out_count],
                   W_OUT);
          errors++;
        end
      end
      out_count++;
      last_out_cycle = cycle;
    end
    if (!RST && READY) begin
      // READY closes the pass right behind the last word
      assert (cycle == last_out_cycle + 1) else begin
        $display("READY did not follow the last W_OUT_ENABLE by one cycle");
        errors++;
      end
      ready_count++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and model
  ////////////////////////////////////////////////////////////

  function automatic ntm_pkg::word_t rand_word(input ntm_pkg::word_t floor_bits);
    bit [31:0] r;
    r = $random(seed);
    return floor_bits | r[15:0];
  endfunction

  // Tap or gate in 0 to 1.0
  function automatic ntm_pkg::gate_t rand_tap();
    bit [31:0] r;
    r = $random(seed);
    return ntm_pkg::gate_t'(r % 257);
  endfunction

  task automatic fill_vectors(input ntm_pkg::word_t floor_bits);
    int j;
    for (j = 0; j < N; j++) begin
      content_v[j]  = rand_word(floor_bits);
      previous_v[j] = rand_word(floor_bits);
    end
  endtask

  // Interpolate, convolve circularly, shift, clamp
  task automatic build_expected(input ntm_pkg::gate_t g, input ntm_pkg::shift_kernel_t s);
    longint wg [N];
    longint sum;
    int     j;
    for (j = 0; j < N; j++) begin
      wg[j] = (longint'(g) * longint'(content_v[j])
             + (longint'(`NTM_ONE) - longint'(g)) * longint'(previous_v[j])) >> 8;
    end
    for (j = 0; j < N; j++) begin
      sum = longint'(s.s_prev) * wg[(j + 1) % N] + longint'(s.s_zero) * wg[j]
          + longint'(s.s_next) * wg[(j + N - 1) % N];
      sum = sum >> 8;
      expected[j] = (sum > 65535) ? 16'hFFFF : ntm_pkg::word_t'(sum);
    end
  endtask

  // One START, N strobes, wait for READY
  task automatic run_pass(input ntm_pkg::gate_t g, input ntm_pkg::shift_kernel_t s,
                          input int max_gap, input bit disturb);
    int j;
    int gap;
    out_count      = 0;
    ready_count    = 0;
    last_out_cycle = -10;
    if (disturb) begin
      // Stray strobe while idle is dropped
      ELEM_IN        = '{content: 16'hFFFF, previous: 16'hFFFF};
      ELEM_IN_ENABLE = 1'b1;
      @(negedge CLK);
      ELEM_IN_ENABLE = 1'b0;
      @(negedge CLK);
    end
    G_IN  = g;
    S_IN  = s;
    START = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    for (j = 0; j < N; j++) begin
      ELEM_IN        = '{content: content_v[j], previous: previous_v[j]};
      ELEM_IN_ENABLE = 1'b1;
      // Second START mid-load with other operands
      if (disturb && j == 3) begin
        START = 1'b1;
        G_IN  = ntm_pkg::gate_t'(0);
        S_IN  = '{s_prev: 9'd256, s_zero: 9'd256, s_next: 9'd256};
      end
      @(negedge CLK);
      ELEM_IN_ENABLE = 1'b0;
      START          = 1'b0;
      gap = (max_gap > 0) ? (($random(seed) & 32'h7FFF_FFFF) % (max_gap + 1)) : 0;
      repeat (gap) @(negedge CLK);
    end
    while (!READY) @(negedge CLK);
    repeat (4) @(negedge CLK);
    assert (out_count == N) else begin
      $display("Pass ended with %0d outputs instead of %0d", out_count, N);
      errors++;
    end
    assert (ready_count == 1) else begin
      $display("READY pulsed %0d times instead of once", ready_count);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == start_errors) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - start_errors);
    end
    start_errors = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int j;
    seed           = 86;
    cycle          = 0;
    errors         = 0;
    start_errors   = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    out_count      = 0;
    ready_count    = 0;
    last_out_cycle = -10;
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    G_IN           = '0;
    S_IN           = '0;
    ELEM_IN        = '0;
    ELEM_IN_ENABLE = 1'b0;
    repeat (8) @(negedge CLK);
    RST = 1'b0;

    // Quiet outputs after reset
    repeat (5) begin
      @(negedge CLK);
      assert (!READY && !W_OUT_ENABLE) else begin
        $display("READY or W_OUT_ENABLE high while idle after reset");
        errors++;
      end
      assert (W_OUT == '0) else begin
        $display("[FAIL] W_OUT expected %h got %h", 16'h0000, W_OUT);
        errors++;
      end
    end
    // With g = 1.0 and the identity kernel the content passes through
    fill_vectors(16'h0000);
    for (j = 0; j < N; j++) begin
      expected[j] = content_v[j];
    end
    run_pass(9'd256, '{s_prev: 9'd0, s_zero: 9'd256, s_next: 9'd0}, 0, 1'b0);
    report_test("Test 1 reset and content passthrough");

    // With g = 0 the previous weighting passes through
    fill_vectors(16'h0000);
    for (j = 0; j < N; j++) begin
      expected[j] = previous_v[j];
    end
    run_pass(9'd0, '{s_prev: 9'd0, s_zero: 9'd256, s_next: 9'd0}, 0, 1'b0);
    report_test("Test 2 previous passthrough");

    // Shift by one so element 0 takes row N-1
    fill_vectors(16'h0000);
    for (j = 0; j < N; j++) begin
      expected[j] = content_v[(j + N - 1) % N];
    end
    run_pass(9'd256, '{s_prev: 9'd0, s_zero: 9'd0, s_next: 9'd256}, 0, 1'b0);
    report_test("Test 3 circular shift");

    // Near-FFFF inputs and a heavy kernel drive saturation
    begin
      ntm_pkg::gate_t         g;
      ntm_pkg::shift_kernel_t s;
      fill_vectors(16'hFF00);
      g = rand_tap();
      // Redraw until the taps sum past 1.0 so the outputs clamp
      do begin
        s = '{s_prev: rand_tap(), s_zero: rand_tap(), s_next: rand_tap()};
      end while (int'(s.s_prev) + int'(s.s_zero) + int'(s.s_next) <= 272);
      build_expected(g, s);
      run_pass(g, s, 0, 1'b0);
      report_test("Test 4 random gate and kernel");
    end

    // Gapped strobes, stray strobe, ignored second START
    begin
      ntm_pkg::gate_t         g;
      ntm_pkg::shift_kernel_t s;
      fill_vectors(16'h0000);
      g = rand_tap();
      s = '{s_prev: rand_tap(), s_zero: rand_tap(), s_next: rand_tap()};
      build_expected(g, s);
      run_pass(g, s, 3, 1'b1);
      report_test("Test 5 gapped input and stray controls");
    end

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: ntm_addressing.f
+incdir+include
source/ntm_pkg.sv
source/ntm_addressing_ctrl.sv
source/ntm_interpolation.sv
source/ntm_weight_buffer.sv
source/ntm_shift_convolution.sv
source/ntm_addressing.sv
sim/ntm_addressing_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the NTM addressing testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ntm_addressing_tb \
  -f ntm_addressing.f -o ntm_addressing_sim \
  && ./obj_dir/ntm_addressing_sim > sim.log 2>&1 \
  || echo "Build or run ended with an error"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
